// ==== all.f ====
hw/ahb_matrix_pkg.sv
hw/ahb_addr_decode.sv
hw/ahb_slave_port.sv
hw/ahb_master_port.sv
hw/ahb_matrix.sv
sim/ahb_matrix_chk.sv
sim/tb_ahb_matrix.sv

// ==== Bender.yml ====
package:
  name: ahb_matrix

sources:
  - hw/ahb_matrix_pkg.sv
  - hw/ahb_addr_decode.sv
  - hw/ahb_slave_port.sv
  - hw/ahb_master_port.sv
  - hw/ahb_matrix.sv
  - target: simulation
    files:
      - sim/ahb_matrix_chk.sv
      - sim/tb_ahb_matrix.sv

// ==== sim/tb_ahb_matrix.sv ====
// ----------------------------------------
// ahb matrix testbench
// two master drivers, two slave models,
// reference model and compare process
// ----------------------------------------
`timescale 1ns/10ps

module tb_ahb_matrix
    import ahb_matrix_pkg::*;
();

    localparam int          clk_half   = 10;
    localparam int          wait_limit = 200;
    localparam int          seq_len    = 12;
    localparam logic [31:0] lfsr_seed  = 32'h3f9f484b;
    // region 7 has no slave behind it
    localparam logic [31:0] addr_none  = 32'h7000_0040;

    // ----------------------------------------
    // DUT signals
    // ----------------------------------------
    logic                               HCLK;
    logic                               HRESETn;
    mst_vec_t                           m_addr_req, m_addr_ack, m_data_ack;
    mst_vec_t                           m_hwrite, m_hresp;
    logic [num_masters-1:0][1:0]        m_htrans;
    logic [num_masters-1:0][2:0]        m_hsize;
    ahb_addr_u [num_masters-1:0]        m_haddr;
    logic [num_masters-1:0][data_w-1:0] m_hwdata, m_hrdata;
    slv_vec_t                           s_addr_req, s_addr_ack, s_data_ack;
    slv_vec_t                           s_hwrite, s_hresp;
    logic [num_slaves-1:0][1:0]         s_htrans;
    logic [num_slaves-1:0][2:0]         s_hsize;
    logic [num_slaves-1:0][addr_w-1:0]  s_haddr;
    logic [num_slaves-1:0][data_w-1:0]  s_hwdata, s_hrdata;

    // slave models
    slv_vec_t    addr_rdy, busy, sl_write;
    logic [7:0]  sl_idx [num_slaves];
    logic [31:0] mem [num_slaves][256];
    logic [31:0] shadow [num_slaves][256];
    logic        wait_en;

    // one outstanding transfer per master
    mst_vec_t    pend_valid, pend_write;
    logic [31:0] pend_addr [num_masters];
    logic [31:0] pend_wdata [num_masters];

    // random sequence built before the wait states start
    logic [31:0] seq_addr [num_masters][seq_len];
    logic        seq_wr [num_masters][seq_len];
    logic [31:0] seq_data [num_masters][seq_len];

    logic [31:0] lfsr;
    int unsigned cycle = 0;

    ahb_matrix DUT (.*);

    // slave takes the address only when its ready flag is up
    assign s_addr_ack = s_addr_req & addr_rdy;

    // ----------------------------------------
    // helpers
    // ----------------------------------------
    function automatic logic [31:0] lfsr_step(input logic [31:0] st);
        // taps 32 22 2 1
        return {st[30:0], st[31] ^ st[21] ^ st[1] ^ st[0]};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr = lfsr_step(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic logic [31:0] word_addr(input int s, input int i);
        return {s[3:0], 18'h0, i[7:0], 2'b00};
    endfunction

    // power up content mixing every address bit
    function automatic logic [31:0] fill_word(input logic [31:0] addr);
        return addr ^ {addr[15:0], addr[31:16]} ^ 32'h5ca1_ab1e;
    endfunction

    // regions 0 and 1 read from the shadow memory, all others the default word
    function automatic logic [31:0] ref_rdata(input logic [31:0] addr);
        if (addr[31:29] == 3'b000)
            return shadow[addr[28]][addr[9:2]];
        return default_rdata;
    endfunction

    task automatic stop_fail(input string why);
        $display("%s", why);
        $display("test failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_word(input string name, input logic [data_w-1:0] got, exp);
        if (got !== exp)
            stop_fail($sformatf("mismatch %s got %h expected %h", name, got, exp));
    endtask

    task automatic check_resp(input string name, input logic got, exp);
        if (got !== exp)
            stop_fail($sformatf("mismatch %s got %h expected %h", name, got, exp));
    endtask

    task automatic check_vec(input string name, input mst_vec_t got, exp);
        if (got !== exp)
            stop_fail($sformatf("mismatch %s got %h expected %h", name, got, exp));
    endtask

    task automatic check_slv(input string name, input slv_vec_t got, exp);
        if (got !== exp)
            stop_fail($sformatf("mismatch %s got %h expected %h", name, got, exp));
    endtask

    task automatic check_trans(input string name, input logic [1:0] got, exp);
        if (got !== exp)
            stop_fail($sformatf("mismatch %s got %h expected %h", name, got, exp));
    endtask

    task automatic check_size(input string name, input logic [2:0] got, exp);
        if (got !== exp)
            stop_fail($sformatf("mismatch %s got %h expected %h", name, got, exp));
    endtask

    task automatic check_region(input string name, input logic [region_w-1:0] got, exp);
        if (got !== exp)
            stop_fail($sformatf("mismatch %s got %h expected %h", name, got, exp));
    endtask

    // ----------------------------------------
    // clock and slave models
    // ----------------------------------------
    initial
    begin
        HCLK = 1'b0;
        forever #clk_half HCLK = ~HCLK;
    end

    always @(posedge HCLK)
        cycle <= cycle + 1;

    // ack, ready and read data change on the falling edge
    always @(negedge HCLK)
    begin
        logic ack_now;
        for (int s = 0; s < num_slaves; s++)
        begin
            ack_now       = busy[s] && (!wait_en || rand_bits(1) != 0);
            s_data_ack[s] = ack_now;
            s_hrdata[s]   = (busy[s] && !sl_write[s]) ? mem[s][sl_idx[s]] : '0;
            s_hresp[s]    = 1'b0;
            // new address only when no data phase stays in flight
            addr_rdy[s]   = (!busy[s] || ack_now) && (!wait_en || rand_bits(1) != 0);
        end
    end

    always @(posedge HCLK or negedge HRESETn)
    begin
        if (!HRESETn)
            busy = '0;
        else
        begin
            for (int s = 0; s < num_slaves; s++)
            begin
                if (busy[s] && s_data_ack[s] && sl_write[s])
                    mem[s][sl_idx[s]] = s_hwdata[s];
                if (s_addr_req[s] && s_addr_ack[s])
                begin
                    // masters issue single word NONSEQ transfers only
                    check_trans($sformatf("s_htrans[%0d]", s), s_htrans[s], 2'b10);
                    check_size($sformatf("s_hsize[%0d]", s), s_hsize[s], 3'b010);
                    // slave n owns region n
                    check_region($sformatf("s_haddr[%0d] region", s),
                                 s_haddr[s][addr_w-1 -: region_w], region_w'(s));
                    busy[s]     = 1'b1;
                    sl_idx[s]   = s_haddr[s][9:2];
                    sl_write[s] = s_hwrite[s];
                end
                else if (s_data_ack[s])
                    busy[s] = 1'b0;
            end
        end
    end

    // ----------------------------------------
    // compare process
    // ----------------------------------------
    always @(posedge HCLK)
    begin
        if (DUT.u_chk.err_cnt != 0)
            stop_fail("protocol assertion failed");
        for (int m = 0; m < num_masters; m++)
        begin
            if (HRESETn && m_data_ack[m])
            begin
                if (!pend_valid[m])
                    stop_fail($sformatf("data ack on master %0d with nothing pending", m));
                check_resp($sformatf("m_hresp[%0d]", m), m_hresp[m], 1'b0);
                if (!pend_write[m])
                    check_word($sformatf("m_hrdata[%0d]", m), m_hrdata[m],
                               ref_rdata(pend_addr[m]));
                else if (pend_addr[m][31:29] == 3'b000)
                    shadow[pend_addr[m][28]][pend_addr[m][9:2]] = pend_wdata[m];
                pend_valid[m] = 1'b0;
            end
        end
    end

    // ----------------------------------------
    // master driver
    // ----------------------------------------
    task automatic run_xfer(input int m, input logic [31:0] addr, input logic wr,
                            input logic [31:0] wdata, output int acc_cyc, output int done_cyc);
        bit seen;
        @(negedge HCLK);
        m_addr_req[m]  = 1'b1;
        m_haddr[m].raw = addr;
        m_hwrite[m]    = wr;
        m_htrans[m]    = 2'b10;
        m_hsize[m]     = 3'b010;
        seen = 1'b0;
        for (int n = 0; n < wait_limit && !seen; n++)
        begin
            @(posedge HCLK);
            seen = m_addr_ack[m];
        end
        if (!seen)
            stop_fail($sformatf("no address ack for master %0d", m));
        pend_addr[m]  = addr;
        pend_write[m] = wr;
        pend_wdata[m] = wdata;
        pend_valid[m] = 1'b1;
        acc_cyc = cycle;
        // write data held through the data phase
        @(negedge HCLK);
        m_addr_req[m] = 1'b0;
        m_htrans[m]   = 2'b00;
        m_hwdata[m]   = wr ? wdata : '0;
        seen = 1'b0;
        for (int n = 0; n < wait_limit && !seen; n++)
        begin
            @(posedge HCLK);
            seen = m_data_ack[m];
        end
        if (!seen)
            stop_fail($sformatf("no data ack for master %0d", m));
        done_cyc = cycle;
    endtask

    task automatic run_seq(input int m);
        int a;
        int d;
        for (int i = 0; i < seq_len; i++)
            run_xfer(m, seq_addr[m][i], seq_wr[m][i], seq_data[m][i], a, d);
    endtask

    task automatic watch_first_ack();
        bit seen;
        seen = 1'b0;
        for (int n = 0; n < wait_limit && !seen; n++)
        begin
            @(posedge HCLK);
            if (|m_addr_ack)
            begin
                check_vec("m_addr_ack", m_addr_ack, mst_vec_t'(1));
                seen = 1'b1;
            end
        end
        if (!seen)
            stop_fail("no address ack while both masters request slave 1");
    endtask

    // ----------------------------------------
    // stimulus
    // ----------------------------------------
    initial
    begin
        int acc0, done0, acc1, done1;
        HRESETn    = 1'b0;
        m_addr_req = '0;
        m_hwrite   = '0;
        m_htrans   = '0;
        m_hsize    = '0;
        m_haddr    = '0;
        m_hwdata   = '0;
        s_data_ack = '0;
        s_hrdata   = '0;
        s_hresp    = '0;
        addr_rdy   = '0;
        busy       = '0;
        sl_write   = '0;
        pend_valid = '0;
        pend_write = '0;
        wait_en    = 1'b0;
        lfsr       = lfsr_seed;
        for (int s = 0; s < num_slaves; s++)
        begin
            sl_idx[s] = '0;
            for (int i = 0; i < 256; i++)
            begin
                mem[s][i]    = fill_word(word_addr(s, i));
                shadow[s][i] = mem[s][i];
            end
        end
        repeat (10) @(posedge HCLK);
        @(negedge HCLK);
        HRESETn = 1'b1;

        // idle after reset
        repeat (3) @(posedge HCLK);
        check_vec("m_addr_ack", m_addr_ack, '0);
        check_vec("m_data_ack", m_data_ack, '0);
        check_slv("s_addr_req", s_addr_req, '0);

        // write then read back, every master to every slave
        for (int m = 0; m < num_masters; m++)
        begin
            for (int s = 0; s < num_slaves; s++)
            begin
                run_xfer(m, word_addr(s, 16 + m), 1'b1, 32'hc0de_0000 | (m << 8) | s,
                         acc0, done0);
                run_xfer(m, word_addr(s, 16 + m), 1'b0, '0, acc0, done0);
            end
        end

        // default slave answers one cycle after the address
        for (int m = 0; m < num_masters; m++)
        begin
            run_xfer(m, addr_none, 1'b0, '0, acc0, done0);
            if (done0 - acc0 != 1)
                stop_fail("default data ack not one cycle after the address ack");
        end

        // both masters hit slave 1 in the same cycle and master 0 goes first
        fork
            run_xfer(0, word_addr(1, 40), 1'b1, 32'h1111_aaaa, acc0, done0);
            run_xfer(1, word_addr(1, 41), 1'b1, 32'h2222_bbbb, acc1, done1);
            watch_first_ack();
        join
        if (acc0 >= acc1)
            stop_fail("master 1 won the address phase over master 0");
        fork
            run_xfer(0, word_addr(1, 41), 1'b0, '0, acc0, done0);
            run_xfer(1, word_addr(1, 40), 1'b0, '0, acc1, done1);
        join

        // different slaves in parallel
        fork
            run_xfer(0, word_addr(0, 60), 1'b1, 32'h0f0f_3c3c, acc0, done0);
            run_xfer(1, word_addr(1, 61), 1'b1, 32'hf0f0_c3c3, acc1, done1);
        join
        if (acc0 != acc1)
            stop_fail("parallel accesses to different slaves were not accepted together");
        fork
            run_xfer(0, word_addr(1, 61), 1'b0, '0, acc0, done0);
            run_xfer(1, word_addr(0, 60), 1'b0, '0, acc1, done1);
        join

        // random traffic with wait states
        for (int m = 0; m < num_masters; m++)
        begin
            for (int i = 0; i < seq_len; i++)
            begin
                seq_addr[m][i] = word_addr(int'(rand_bits(1)), 48 + int'(rand_bits(3)));
                seq_wr[m][i]   = rand_bits(1) != 0;
                seq_data[m][i] = rand_bits(32);
            end
        end
        wait_en = 1'b1;
        fork
            run_seq(0);
            run_seq(1);
        join
        wait_en = 1'b0;

        repeat (4) @(posedge HCLK);
        if (pend_valid != '0)
            stop_fail("transfer left without a data phase");
        if (DUT.u_chk.err_cnt != 0)
            stop_fail("protocol assertion failed");
        else
        begin
            $display("test passed");
            $finish;
        end
    end

endmodule

// ==== sim/ahb_matrix_chk.sv ====
// ----------------------------------------
// ahb matrix protocol checks
// bound into the matrix top level
// ----------------------------------------
`timescale 1ns/10ps

module ahb_matrix_chk
    import ahb_matrix_pkg::*;
(
    input logic                        HCLK,
    input logic                        HRESETn,
    input mst_vec_t                    m_addr_req,
    input ahb_addr_u [num_masters-1:0] m_haddr,
    input mst_vec_t                    m_addr_ack,
    input mst_vec_t                    m_data_ack,
    input slv_vec_t                    s_addr_req,
    input mst_vec_t [num_slaves-1:0]   slv_addr_ack,
    input mst_vec_t                    addr_default
);

    int unsigned err_cnt = 0;

    // masters whose live address falls in each slave region
    mst_vec_t [num_slaves-1:0] maps;

    for (genvar s = 0; s < num_slaves; s++)
    begin : g_slv
        for (genvar m = 0; m < num_masters; m++)
        begin : g_map
            assign maps[s][m] = m_addr_req[m] && (m_haddr[m].fld.region == slave_region[s]);
        end

        // one winner per slave and cycle
        a_one_ack: assert property (@(posedge HCLK) disable iff (!HRESETn)
            $onehot0(slv_addr_ack[s]))
        else
        begin
            err_cnt++;
            $error("slave %0d acked more than one master", s);
        end

        // no slave request without a matching master
        a_req_mapped: assert property (@(posedge HCLK) disable iff (!HRESETn)
            s_addr_req[s] |-> (|maps[s]))
        else
        begin
            err_cnt++;
            $error("slave %0d requested with no master in its region", s);
        end
    end

    // default slave data phase is one cycle long
    for (genvar m = 0; m < num_masters; m++)
    begin : g_mst
        a_dflt_data: assert property (@(posedge HCLK) disable iff (!HRESETn)
            (m_addr_ack[m] && addr_default[m]) |=> m_data_ack[m])
        else
        begin
            err_cnt++;
            $error("master %0d default data ack missing", m);
        end
    end

endmodule

bind ahb_matrix ahb_matrix_chk u_chk (
    .HCLK         (HCLK),
    .HRESETn      (HRESETn),
    .m_addr_req   (m_addr_req),
    .m_haddr      (m_haddr),
    .m_addr_ack   (m_addr_ack),
    .m_data_ack   (m_data_ack),
    .s_addr_req   (s_addr_req),
    .slv_addr_ack (slv_addr_ack),
    .addr_default (addr_default)
);

// ==== hw/ahb_matrix.sv ====
// ----------------------------------------
// ahb interconnect matrix
// two masters to two slaves with per slave
// arbitration and a default slave
// ----------------------------------------
`timescale 1ns/10ps

module ahb_matrix
    import ahb_matrix_pkg::*;
(
    input  logic                                HCLK,
    input  logic                                HRESETn,
    // master side
    input  mst_vec_t                            m_addr_req,
    output mst_vec_t                            m_addr_ack,
    output mst_vec_t                            m_data_ack,
    input  logic      [num_masters-1:0][1:0]    m_htrans,
    input  mst_vec_t                            m_hwrite,
    input  logic      [num_masters-1:0][2:0]    m_hsize,
    input  ahb_addr_u [num_masters-1:0]         m_haddr,
    input  logic [num_masters-1:0][data_w-1:0]  m_hwdata,
    output logic [num_masters-1:0][data_w-1:0]  m_hrdata,
    output mst_vec_t                            m_hresp,
    // slave side
    output slv_vec_t                            s_addr_req,
    input  slv_vec_t                            s_addr_ack,
    input  slv_vec_t                            s_data_ack,
    output logic [num_slaves-1:0][1:0]          s_htrans,
    output slv_vec_t                            s_hwrite,
    output logic [num_slaves-1:0][2:0]          s_hsize,
    output logic [num_slaves-1:0][addr_w-1:0]   s_haddr,
    output logic [num_slaves-1:0][data_w-1:0]   s_hwdata,
    input  logic [num_slaves-1:0][data_w-1:0]   s_hrdata,
    input  slv_vec_t                            s_hresp
);

    // decode results
    mst_vec_t [num_slaves-1:0]  slv_req;
    mst_vec_t                   addr_default;
    mst_vec_t                   data_default;

    // slave indexed returns and their master indexed copies
    mst_vec_t [num_slaves-1:0]  slv_addr_ack;
    mst_vec_t [num_slaves-1:0]  slv_data_owner;
    slv_vec_t [num_masters-1:0] mst_addr_ack;
    slv_vec_t [num_masters-1:0] mst_data_owner;

    // ----------------------------------------
    // address decode
    // ----------------------------------------
    ahb_addr_decode u_decode (
        .HCLK         (HCLK),
        .HRESETn      (HRESETn),
        .m_addr_req   (m_addr_req),
        .m_haddr      (m_haddr),
        .slv_req      (slv_req),
        .addr_default (addr_default),
        .data_default (data_default)
    );

    // ----------------------------------------
    // slave ports
    // ----------------------------------------
    for (genvar s = 0; s < num_slaves; s++)
    begin : g_slave
        ahb_slave_port u_slave_port (
            .HCLK       (HCLK),
            .HRESETn    (HRESETn),
            .req        (slv_req[s]),
            .m_addr_req (m_addr_req),
            .m_hwrite   (m_hwrite),
            .m_htrans   (m_htrans),
            .m_hsize    (m_hsize),
            .m_haddr    (m_haddr),
            .m_hwdata   (m_hwdata),
            .s_addr_req (s_addr_req[s]),
            .s_hwrite   (s_hwrite[s]),
            .s_htrans   (s_htrans[s]),
            .s_hsize    (s_hsize[s]),
            .s_haddr    (s_haddr[s]),
            .s_hwdata   (s_hwdata[s]),
            .s_addr_ack (s_addr_ack[s]),
            .s_data_ack (s_data_ack[s]),
            .addr_ack   (slv_addr_ack[s]),
            .data_owner (slv_data_owner[s])
        );
    end

    // ----------------------------------------
    // slave to master transpose
    // ----------------------------------------
    for (genvar m = 0; m < num_masters; m++)
    begin : g_xpose_m
        for (genvar s = 0; s < num_slaves; s++)
        begin : g_xpose_s
            assign mst_addr_ack[m][s]   = slv_addr_ack[s][m];
            assign mst_data_owner[m][s] = slv_data_owner[s][m];
        end
    end

    // ----------------------------------------
    // master ports
    // ----------------------------------------
    for (genvar m = 0; m < num_masters; m++)
    begin : g_master
        ahb_master_port u_master_port (
            .addr_default (addr_default[m]),
            .data_default (data_default[m]),
            .addr_ack_in  (mst_addr_ack[m]),
            .data_owner   (mst_data_owner[m]),
            .s_data_ack   (s_data_ack),
            .s_hrdata     (s_hrdata),
            .s_hresp      (s_hresp),
            .m_addr_ack   (m_addr_ack[m]),
            .m_data_ack   (m_data_ack[m]),
            .m_hresp      (m_hresp[m]),
            .m_hrdata     (m_hrdata[m])
        );
    end

endmodule

// ==== hw/ahb_master_port.sv ====
// ----------------------------------------
// ahb master port
// collects acks, read data and response
// for one master, default slave included
// ----------------------------------------
`timescale 1ns/10ps

module ahb_master_port
    import ahb_matrix_pkg::*;
(
    // default slave flags of this master
    input  logic                               addr_default,
    input  logic                               data_default,
    // per slave views of this master
    input  slv_vec_t                           addr_ack_in,
    input  slv_vec_t                           data_owner,
    // slave data phase signals
    input  slv_vec_t                           s_data_ack,
    input  logic [num_slaves-1:0][data_w-1:0]  s_hrdata,
    input  slv_vec_t                           s_hresp,
    // to the master
    output logic                               m_addr_ack,
    output logic                               m_data_ack,
    output logic                               m_hresp,
    output logic [data_w-1:0]                  m_hrdata
);

    // ----------------------------------------
    // address phase return
    // ----------------------------------------
    // at most one slave grants this master per cycle
    // default slave answers without waiting
    assign m_addr_ack = addr_default | (|addr_ack_in);

    // ----------------------------------------
    // data phase return
    // ----------------------------------------
    always_comb
    begin
        m_data_ack = 1'b0;
        m_hrdata   = '0;
        m_hresp    = 1'b0;
        if (data_default)
        begin
            // fixed answer with OKAY response
            m_data_ack = 1'b1;
            m_hrdata   = default_rdata;
            m_hresp    = 1'b0;
        end
        else
        begin
            // pass through the slave owning our data phase
            for (int s = 0; s < num_slaves; s++)
            begin
                if (data_owner[s])
                begin
                    m_data_ack = s_data_ack[s];
                    m_hrdata   = s_hrdata[s];
                    m_hresp    = s_hresp[s];
                end
            end
        end
    end

endmodule

// ==== hw/ahb_slave_port.sv ====
// ----------------------------------------
// ahb slave port
// fixed priority grant for one slave,
// address phase mux and data phase owner
// ----------------------------------------
`timescale 1ns/10ps

module ahb_slave_port
    import ahb_matrix_pkg::*;
(
    input  logic                                HCLK,
    input  logic                                HRESETn,
    // decoded requests for this slave
    input  mst_vec_t                            req,
    // master side address and write data
    input  mst_vec_t                            m_addr_req,
    input  mst_vec_t                            m_hwrite,
    input  logic      [num_masters-1:0][1:0]    m_htrans,
    input  logic      [num_masters-1:0][2:0]    m_hsize,
    input  ahb_addr_u [num_masters-1:0]         m_haddr,
    input  logic [num_masters-1:0][data_w-1:0]  m_hwdata,
    // slave side
    output logic                                s_addr_req,
    output logic                                s_hwrite,
    output logic      [1:0]                     s_htrans,
    output logic      [2:0]                     s_hsize,
    output logic      [addr_w-1:0]              s_haddr,
    output logic      [data_w-1:0]              s_hwdata,
    input  logic                                s_addr_ack,
    input  logic                                s_data_ack,
    // back to the master ports
    output mst_vec_t                            addr_ack,
    output mst_vec_t                            data_owner
);

    // one-hot winner of the address phase
    mst_vec_t grant;

    // ----------------------------------------
    // arbitration
    // ----------------------------------------
    // lowest set bit wins, so master 0 has top priority
    assign grant = req & (~req + mst_vec_t'(1));

    // ack only the winner, and only when the slave takes it
    assign addr_ack = grant & {num_masters{s_addr_ack}};

    // ----------------------------------------
    // address phase mux
    // ----------------------------------------
    always_comb
    begin
        s_addr_req = 1'b0;
        s_hwrite   = 1'b0;
        s_htrans   = '0;
        s_hsize    = '0;
        s_haddr    = '0;
        for (int m = 0; m < num_masters; m++)
        begin
            if (grant[m])
            begin
                s_addr_req = m_addr_req[m];
                s_hwrite   = m_hwrite[m];
                s_htrans   = m_htrans[m];
                s_hsize    = m_hsize[m];
                // slaves see the plain address
                s_haddr    = m_haddr[m].raw;
            end
        end
    end

    // ----------------------------------------
    // data phase owner
    // ----------------------------------------
    // loads on an accepted address, clears when the data phase ends;
    // a new address on the same edge takes over the slot
    always_ff @(posedge HCLK or negedge HRESETn)
    begin
        if (!HRESETn)
            data_owner <= '0;
        else if (s_addr_req && s_addr_ack)
            data_owner <= grant;
        else if (s_data_ack)
            data_owner <= '0;
    end

    // write data follows the owner, not the current grant
    always_comb
    begin
        s_hwdata = '0;
        for (int m = 0; m < num_masters; m++)
        begin
            if (data_owner[m])
            begin
                s_hwdata = m_hwdata[m];
            end
        end
    end

endmodule

// ==== hw/ahb_addr_decode.sv ====
// ----------------------------------------
// ahb address decode
// maps every master address to a slave hit
// or to the default slave
// ----------------------------------------
`timescale 1ns/10ps

module ahb_addr_decode
    import ahb_matrix_pkg::*;
(
    input  logic                        HCLK,
    input  logic                        HRESETn,
    input  mst_vec_t                    m_addr_req,
    input  ahb_addr_u [num_masters-1:0] m_haddr,
    output mst_vec_t  [num_slaves-1:0]  slv_req,
    output mst_vec_t                    addr_default,
    output mst_vec_t                    data_default
);

    // hits seen from the master side, one slave vector each
    slv_vec_t [num_masters-1:0] hit;

    // ----------------------------------------
    // region compare
    // ----------------------------------------
    always_comb
    begin
        for (int m = 0; m < num_masters; m++)
        begin
            for (int s = 0; s < num_slaves; s++)
            begin
                // only a live request can hit
                hit[m][s] = m_addr_req[m] & (m_haddr[m].fld.region == slave_region[s]);
            end
        end
    end

    // transpose into per slave request vectors
    always_comb
    begin
        for (int s = 0; s < num_slaves; s++)
        begin
            for (int m = 0; m < num_masters; m++)
            begin
                slv_req[s][m] = hit[m][s];
            end
        end
    end

    // requesting but no slave owns the region
    always_comb
    begin
        for (int m = 0; m < num_masters; m++)
        begin
            addr_default[m] = m_addr_req[m] & ~(|hit[m]);
        end
    end

    // ----------------------------------------
    // default data phase
    // ----------------------------------------
    // default address is acked at once, data one cycle later
    always_ff @(posedge HCLK or negedge HRESETn)
    begin
        if (!HRESETn)
            data_default <= '0;
        else
            data_default <= addr_default;
    end

endmodule

// ==== hw/ahb_matrix_pkg.sv ====
// ----------------------------------------
// ahb matrix package
// bus sizes, fixed region map and the
// vector and address types of the matrix
// ----------------------------------------

package ahb_matrix_pkg;

    // ----------------------------------------
    // sizes
    // ----------------------------------------
    localparam int num_masters = 2;
    localparam int num_slaves  = 2;
    localparam int addr_w      = 32;
    localparam int data_w      = 32;

    // region field is the top nibble of the address
    localparam int region_w = 4;
    localparam int offset_w = addr_w - region_w;

    // ----------------------------------------
    // region map
    // ----------------------------------------
    // entry n is the region owned by slave n
    localparam logic [num_slaves-1:0][region_w-1:0] slave_region = {4'h1, 4'h0};

    // returned by the default slave on unmapped reads
    localparam logic [data_w-1:0] default_rdata = 32'hdead_dead;

    // ----------------------------------------
    // types
    // ----------------------------------------
    // one bit per master
    typedef logic [num_masters-1:0] mst_vec_t;

    // one bit per slave
    typedef logic [num_slaves-1:0] slv_vec_t;

    // address word in raw or split view
    typedef struct packed {
        logic [region_w-1:0] region;
        logic [offset_w-1:0] offset;
    } ahb_addr_fld_t;

    typedef union packed {
        logic [addr_w-1:0] raw;
        ahb_addr_fld_t     fld;
    } ahb_addr_u;

endpackage
